/* common/mtx_pkg.sv */
// bus matrix shared definitions
// bus widths, AHB encodings, request and data-phase records

`default_nettype none

package mtx_pkg;

   // ----------------------------------------------------------------------
   // bus constants
   // ----------------------------------------------------------------------

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // top nibble of the private peripheral bus region
   localparam logic [3:0] PPB_NIBBLE = 4'hE;

   // stored select index width, holds up to 63 selects plus "none"
   localparam int PPB_IDX_W = 6;

   // AHB encodings driven by the matrix
   localparam logic [1:0] HTRANS_IDLE   = 2'b00;
   localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
   localparam logic [2:0] HBURST_SINGLE = 3'b000;

   // ----------------------------------------------------------------------
   // types
   // ----------------------------------------------------------------------

   typedef enum logic [1:0] {
      SIZE_BYTE = 2'b00,
      SIZE_HALF = 2'b01,
      SIZE_WORD = 2'b10
   } size_t;

   // hmaster encoding, core is 0 and debug is 1
   typedef enum logic {
      MASTER_CORE  = 1'b0,
      MASTER_DEBUG = 1'b1
   } master_e;

   // core load/store/fetch port, address phase
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      size_t             size;
      logic              write;
      logic              data_not_fetch;
      logic              spec_trans;   // core may be starting a transfer
      logic              ext_trans;    // transfer to external AHB
      logic              ppb_trans;    // transfer to PPB
   } core_req_t;

   // debug slave port, address phase
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      size_t             size;
      logic              write;
      logic              trans;
   } dbg_req_t;

   // arbitrated address phase
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      size_t             size;
      logic              write;
      logic              data_not_fetch;
      master_e           master;
      logic              ext_trans;
      logic              ppb_trans;
   } bus_req_t;

   // hprot[3:2] attributes from the memory map
   typedef struct packed {
      logic cacheable;
      logic bufferable;
   } mem_attr_t;

   // registered data-phase state
   typedef struct packed {
      logic                 valid;
      master_e              master;
      logic                 ppb;
      logic                 write;
      logic [PPB_IDX_W-1:0] sel_idx;
   } dphase_t;

endpackage

`default_nettype wire

/* matrix/mtx_addr_decode.sv */
// address decode for the bus matrix
// flags PPB space, derives cacheable/bufferable from the memory map
// and extracts the PPB word register index

`timescale 1ns/100ps
`default_nettype none

module mtx_addr_decode
   import mtx_pkg::*;
   #(parameter int NUM_PPB_SEL = 16,
     localparam int IDX_W      = $clog2(NUM_PPB_SEL) + 1)
   (input  wire logic [ADDR_W-1:0] addr_i,      // candidate address
    output mem_attr_t              attr_o,      // cacheable / bufferable
    output logic                   is_ppb_o,    // address in PPB space
    output logic [IDX_W-1:0]       sel_idx_o);  // PPB word index

   // index value that matches no select
   localparam logic [IDX_W-1:0] SEL_NONE = IDX_W'(NUM_PPB_SEL);

   logic in_range;

   // ----------------------------------------------------------------------
   // region decode
   // ----------------------------------------------------------------------

   // PPB covers the whole 0xE region
   assign is_ppb_o = (addr_i[ADDR_W-1 -: 4] == PPB_NIBBLE);

   //  prefix  region       C  B
   //  000x    normal-wt    1  0
   //  001x    normal-wbwa  1  1
   //  010x    device       0  1
   //  011x    normal-wbwa  1  1
   //  100x    normal-wt    1  0
   //  101x    device       0  1
   //  110x    device       0  1
   //  1111    device       0  1
   assign attr_o.cacheable  = (~addr_i[31] &  addr_i[29]) |
                              (~addr_i[30] & ~addr_i[29]);
   assign attr_o.bufferable = addr_i[30] | addr_i[29];

   // ----------------------------------------------------------------------
   // PPB word select index
   // ----------------------------------------------------------------------

   // word registers start at bit 2, anything past the last one
   // gets the out of range index
   assign in_range  = (addr_i[27:2] < NUM_PPB_SEL);
   assign sel_idx_o = in_range ? addr_i[2 +: IDX_W] : SEL_NONE;

endmodule

`default_nettype wire

/* matrix/mtx_arbiter.sv */
// address-phase arbiter for the bus matrix
// grants the bus to the debug port in non-speculative core cycles,
// otherwise to the core, and builds the arbitrated request

`timescale 1ns/100ps
`default_nettype none

module mtx_arbiter
   import mtx_pkg::*;
   #(parameter int NUM_PPB_SEL = 16,
     localparam int IDX_W      = $clog2(NUM_PPB_SEL) + 1)
   (input  core_req_t        core_req_i,   // core address phase
    input  dbg_req_t         dbg_req_i,    // debug address phase
    output bus_req_t         bus_req_o,    // winning address phase
    output mem_attr_t        attr_o,       // attributes of winning address
    output logic [IDX_W-1:0] sel_idx_o,    // PPB word index
    output logic             dif_slot_o);  // slot free for debug

   logic              dif_slot;
   logic              dif_aphase;
   logic [ADDR_W-1:0] bus_addr;
   logic              is_ppb;

   // ----------------------------------------------------------------------
   // slot and grant
   // ----------------------------------------------------------------------

   // debug only gets cycles where the core cannot be transferring,
   // spec_trans is early so it is used as-is for timing
   assign dif_slot   = ~core_req_i.spec_trans;
   assign dif_aphase = dif_slot & dbg_req_i.trans;

   assign bus_addr = dif_aphase ? dbg_req_i.addr : core_req_i.addr;

   // ----------------------------------------------------------------------
   // decode of the granted address
   // ----------------------------------------------------------------------

   mtx_addr_decode #(
      .NUM_PPB_SEL (NUM_PPB_SEL)
   ) u_decode (
      .addr_i    (bus_addr),
      .attr_o    (attr_o),
      .is_ppb_o  (is_ppb),
      .sel_idx_o (sel_idx_o)
   );

   // ----------------------------------------------------------------------
   // arbitrated request
   // ----------------------------------------------------------------------

   always_comb begin
      bus_req_o.addr  = bus_addr;
      bus_req_o.size  = dif_aphase ? dbg_req_i.size  : core_req_i.size;
      bus_req_o.write = dif_aphase ? dbg_req_i.write : core_req_i.write;
      // debug accesses are always data
      bus_req_o.data_not_fetch = core_req_i.data_not_fetch | dif_aphase;
      bus_req_o.master = dif_aphase ? MASTER_DEBUG : MASTER_CORE;
      if (dif_aphase) begin
         // debug routing comes from the local decode
         bus_req_o.ext_trans = ~is_ppb;
         bus_req_o.ppb_trans =  is_ppb;
      end else begin
         bus_req_o.ext_trans = core_req_i.ext_trans;
         // core fetches from PPB are thrown away
         bus_req_o.ppb_trans = core_req_i.ppb_trans & core_req_i.data_not_fetch;
      end
   end

   assign dif_slot_o = dif_slot;

endmodule

`default_nettype wire

/* matrix/mtx_dphase.sv */
// data-phase stage of the bus matrix
// tracks the accepted transfer across hready and steers write-data,
// read-data, error responses and the one-hot PPB selects

`timescale 1ns/100ps
`default_nettype none

module mtx_dphase
   import mtx_pkg::*;
   #(parameter int NUM_PPB_SEL = 16,
     localparam int IDX_W      = $clog2(NUM_PPB_SEL) + 1)
   (input  wire logic                   hclk,
    input  wire logic                   arst_n_i,
    input  wire logic                   hready_i,      // AHB ready
    input  bus_req_t                    bus_req_i,     // address phase
    input  wire logic [IDX_W-1:0]       sel_idx_i,     // PPB word index
    input  wire logic [DATA_W-1:0]      core_wdata_i,  // core write-data
    input  wire logic [DATA_W-1:0]      dbg_wdata_i,   // debug write-data
    input  wire logic [DATA_W-1:0]      hrdata_i,      // AHB read-data
    input  wire logic [DATA_W-1:0]      ppb_rdata_i,   // PPB read-data
    input  wire logic                   hresp_i,       // AHB error
    output logic      [DATA_W-1:0]      hwdata_o,      // AHB write-data
    output logic      [DATA_W-1:0]      ppb_wdata_o,   // masked PPB write-data
    output logic      [NUM_PPB_SEL-1:0] ppb_sels_o,    // PPB register selects
    output logic                        ppb_active_o,  // PPB data phase
    output logic                        ppb_write_o,   // PPB data phase write
    output logic      [DATA_W-1:0]      dif_rdata_o,   // read-data to debug
    output logic                        dif_resp_o,    // error to debug
    output logic                        cpu_resp_o);   // error to core

   dphase_t dphase_q;
   logic    dbg_dphase;
   logic    core_dphase;

   // ----------------------------------------------------------------------
   // data-phase register
   // ----------------------------------------------------------------------

   // loads on every ready edge, holds while the slave stalls
   always_ff @(posedge hclk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dphase_q <= '0;
      end else if (hready_i) begin
         dphase_q.valid   <= bus_req_i.ext_trans | bus_req_i.ppb_trans;
         dphase_q.master  <= bus_req_i.master;
         dphase_q.ppb     <= bus_req_i.ppb_trans;
         dphase_q.write   <= bus_req_i.write;
         dphase_q.sel_idx <= PPB_IDX_W'(sel_idx_i);
      end
   end

   assign dbg_dphase  = dphase_q.valid & (dphase_q.master == MASTER_DEBUG);
   assign core_dphase = dphase_q.valid & (dphase_q.master == MASTER_CORE);

   assign ppb_active_o = dphase_q.valid & dphase_q.ppb;
   assign ppb_write_o  = ppb_active_o & dphase_q.write;

   // ----------------------------------------------------------------------
   // write-data
   // ----------------------------------------------------------------------

   assign hwdata_o = dbg_dphase ? dbg_wdata_i : core_wdata_i;

   // PPB writes are rare, keep its write bus quiet otherwise
   assign ppb_wdata_o = {DATA_W{ppb_write_o}} & hwdata_o;

   // ----------------------------------------------------------------------
   // PPB register selects
   // ----------------------------------------------------------------------

   // out of range index matches no bit
   always_comb begin
      for (int i = 0; i < NUM_PPB_SEL; i++) begin
         ppb_sels_o[i] = ppb_active_o & (dphase_q.sel_idx == PPB_IDX_W'(i));
      end
   end

   // ----------------------------------------------------------------------
   // read-data and responses
   // ----------------------------------------------------------------------

   // debugger sees PPB data in a PPB data phase, AHB data otherwise
   assign dif_rdata_o = ppb_active_o ? ppb_rdata_i : hrdata_i;

   // keep debug errors away from the core
   assign dif_resp_o = hresp_i & dbg_dphase;
   assign cpu_resp_o = hresp_i & core_dphase;

endmodule

`default_nettype wire

/* matrix/mtx_top.sv */
// AHB-Lite bus matrix for the core and the debug slave port
// arbitration and decode in the address phase, steering in the
// data phase, drives the AHB master outputs

`timescale 1ns/100ps
`default_nettype none

module mtx_top
   import mtx_pkg::*;
   #(parameter int NUM_PPB_SEL = 16)
   (input  wire logic                   hclk,          // AHB clock
    input  wire logic                   arst_n_i,      // async reset
    input  core_req_t                   core_req_i,    // core address phase
    input  dbg_req_t                    dbg_req_i,     // debug address phase
    input  wire logic [DATA_W-1:0]      core_wdata_i,  // core write-data
    input  wire logic [DATA_W-1:0]      dbg_wdata_i,   // debug write-data
    input  wire logic [DATA_W-1:0]      hrdata_i,      // AHB read-data
    input  wire logic                   hready_i,      // AHB ready
    input  wire logic                   hresp_i,       // AHB error
    input  wire logic [DATA_W-1:0]      ppb_rdata_i,   // PPB read-data
    output logic      [ADDR_W-1:0]      haddr_o,
    output logic      [1:0]             htrans_o,
    output logic      [2:0]             hsize_o,
    output logic      [3:0]             hprot_o,
    output logic                        hwrite_o,
    output logic                        hmaster_o,     // 0 core, 1 debug
    output logic      [2:0]             hburst_o,
    output logic                        hmastlock_o,
    output logic      [DATA_W-1:0]      hwdata_o,
    output logic      [DATA_W-1:0]      ppb_wdata_o,   // PPB write-data
    output logic      [NUM_PPB_SEL-1:0] ppb_sels_o,    // PPB register selects
    output logic                        ppb_active_o,  // PPB data phase
    output logic                        ppb_write_o,   // PPB write data phase
    output logic      [DATA_W-1:0]      dif_rdata_o,   // read-data to debug
    output logic                        dif_resp_o,    // error to debug
    output logic                        cpu_resp_o,    // error to core
    output logic                        dif_slot_o);   // slot free for debug

   localparam int IDX_W = $clog2(NUM_PPB_SEL) + 1;

   bus_req_t         bus_req;
   mem_attr_t        attr;
   logic [IDX_W-1:0] sel_idx;

   // ----------------------------------------------------------------------
   // address phase
   // ----------------------------------------------------------------------

   mtx_arbiter #(
      .NUM_PPB_SEL (NUM_PPB_SEL)
   ) u_arbiter (
      .core_req_i (core_req_i),
      .dbg_req_i  (dbg_req_i),
      .bus_req_o  (bus_req),
      .attr_o     (attr),
      .sel_idx_o  (sel_idx),
      .dif_slot_o (dif_slot_o)
   );

   // ----------------------------------------------------------------------
   // data phase
   // ----------------------------------------------------------------------

   mtx_dphase #(
      .NUM_PPB_SEL (NUM_PPB_SEL)
   ) u_dphase (
      .hclk         (hclk),
      .arst_n_i     (arst_n_i),
      .hready_i     (hready_i),
      .bus_req_i    (bus_req),
      .sel_idx_i    (sel_idx),
      .core_wdata_i (core_wdata_i),
      .dbg_wdata_i  (dbg_wdata_i),
      .hrdata_i     (hrdata_i),
      .ppb_rdata_i  (ppb_rdata_i),
      .hresp_i      (hresp_i),
      .hwdata_o     (hwdata_o),
      .ppb_wdata_o  (ppb_wdata_o),
      .ppb_sels_o   (ppb_sels_o),
      .ppb_active_o (ppb_active_o),
      .ppb_write_o  (ppb_write_o),
      .dif_rdata_o  (dif_rdata_o),
      .dif_resp_o   (dif_resp_o),
      .cpu_resp_o   (cpu_resp_o)
   );

   // ----------------------------------------------------------------------
   // AHB master outputs
   // ----------------------------------------------------------------------

   // PPB transfers stay off AHB, only external ones go out as NONSEQ
   assign htrans_o = bus_req.ext_trans ? HTRANS_NONSEQ : HTRANS_IDLE;
   assign haddr_o  = bus_req.addr;
   assign hsize_o  = {1'b0, bus_req.size};
   assign hwrite_o = bus_req.write;
   assign hmaster_o = bus_req.master;

   // C, B, always privileged, data not fetch
   assign hprot_o = {attr.cacheable, attr.bufferable, 1'b1, bus_req.data_not_fetch};

   // single transfers only, never locked
   assign hburst_o    = HBURST_SINGLE;
   assign hmastlock_o = 1'b0;

endmodule

`default_nettype wire

/* test/tb_clkgen.sv */
// testbench clock and reset generator
// free-running clock, reset held low for a set number of cycles

`timescale 1ns/100ps
`default_nettype none

module tb_clkgen
   #(parameter int PERIOD     = 10,
     parameter int RST_CYCLES = 4)
   (output logic clk_o,       // test clock
    output logic arst_n_o);   // active-low reset

   // clock starts low, first rising edge at half a period
   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD / 2);
         clk_o = ~clk_o;
      end
   end

   // release on a falling edge, away from the sampling edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

/* test/tb_mtx_top.sv */
// testbench for the AHB-Lite bus matrix
// table-driven, address phase checked in its own cycle,
// data phase checked after the accepting hready edge

`timescale 1ns/100ps
`default_nettype none

module tb_mtx_top
   import mtx_pkg::*;
   ();

   localparam int CLK_PERIOD  = 10;
   localparam int NUM_PPB_SEL = 16;
   localparam int NUM_ROWS    = 18;

   // stimulus half of a row
   typedef struct packed {
      logic       spec;     // core spec_trans
      logic       dtrans;   // debug trans
      logic       cext;     // core ext_trans
      logic       cppb;     // core ppb_trans
      logic       cdnf;     // core data_not_fetch
      logic [3:0] region;   // top address nibble
      logic [7:0] word;     // PPB word index, PPB rows only
      logic       write;    // write flag of the winner
      logic [2:0] stall;    // hready low cycles in the data phase
      logic       hresp;
   } stim_t;

   // expected half of a row
   typedef struct packed {
      logic                   nonseq;   // external transfer on AHB
      master_e                master;
      mem_attr_t              attr;
      logic                   dnf;      // hprot data bit
      logic                   ppb;      // PPB data phase
      logic [NUM_PPB_SEL-1:0] sels;
      logic                   dresp;
      logic                   cresp;
   } expect_t;

   // ---------------------------------------------------------------------
   // transfer table
   // ---------------------------------------------------------------------

   //  spec  dtr   cext  cppb  cdnf  reg   word   wr    stall hresp
   stim_t stim_tab [NUM_ROWS] = '{
      {1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 4'h0, 8'd0,  1'b0, 3'd0, 1'b0},
      {1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 4'h3, 8'd0,  1'b1, 3'd0, 1'b1},
      {1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 4'h4, 8'd0,  1'b0, 3'd0, 1'b0},
      {1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 4'h7, 8'd0,  1'b1, 3'd0, 1'b0},
      {1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 4'h9, 8'd0,  1'b0, 3'd0, 1'b0},
      {1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 4'hA, 8'd0,  1'b0, 3'd0, 1'b0},
      {1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 4'hD, 8'd0,  1'b0, 3'd0, 1'b0},
      {1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 4'hF, 8'd0,  1'b0, 3'd0, 1'b0},
      {1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 4'h2, 8'd0,  1'b0, 3'd0, 1'b1},
      {1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 4'h6, 8'd0,  1'b1, 3'd0, 1'b0},
      {1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 4'hE, 8'd3,  1'b1, 3'd0, 1'b0},
      {1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 4'hE, 8'd15, 1'b0, 3'd0, 1'b0},
      {1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 4'hE, 8'd5,  1'b1, 3'd0, 1'b0},
      {1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 4'hE, 8'd7,  1'b0, 3'd0, 1'b1},
      {1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 4'hE, 8'd64, 1'b0, 3'd0, 1'b0},
      {1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 4'hE, 8'd9,  1'b0, 3'd3, 1'b0},
      {1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 4'h0, 8'd0,  1'b0, 3'd2, 1'b1},
      {1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'h1, 8'd0,  1'b0, 3'd0, 1'b1}
   };

   //  nseq  master        C B    dnf   ppb   sels      dresp cresp
   expect_t expect_tab [NUM_ROWS] = '{
      {1'b1, MASTER_CORE,  2'b10, 1'b0, 1'b0, 16'h0000, 1'b0, 1'b0},
      {1'b1, MASTER_CORE,  2'b11, 1'b1, 1'b0, 16'h0000, 1'b0, 1'b1},
      {1'b1, MASTER_CORE,  2'b01, 1'b1, 1'b0, 16'h0000, 1'b0, 1'b0},
      {1'b1, MASTER_CORE,  2'b11, 1'b1, 1'b0, 16'h0000, 1'b0, 1'b0},
      {1'b1, MASTER_CORE,  2'b10, 1'b1, 1'b0, 16'h0000, 1'b0, 1'b0},
      {1'b1, MASTER_CORE,  2'b01, 1'b1, 1'b0, 16'h0000, 1'b0, 1'b0},
      {1'b1, MASTER_CORE,  2'b01, 1'b1, 1'b0, 16'h0000, 1'b0, 1'b0},
      {1'b1, MASTER_CORE,  2'b01, 1'b0, 1'b0, 16'h0000, 1'b0, 1'b0},
      {1'b1, MASTER_DEBUG, 2'b11, 1'b1, 1'b0, 16'h0000, 1'b1, 1'b0},
      {1'b1, MASTER_DEBUG, 2'b11, 1'b1, 1'b0, 16'h0000, 1'b0, 1'b0},
      {1'b0, MASTER_DEBUG, 2'b01, 1'b1, 1'b1, 16'h0008, 1'b0, 1'b0},
      {1'b0, MASTER_DEBUG, 2'b01, 1'b1, 1'b1, 16'h8000, 1'b0, 1'b0},
      {1'b0, MASTER_CORE,  2'b01, 1'b1, 1'b1, 16'h0020, 1'b0, 1'b0},
      {1'b0, MASTER_CORE,  2'b01, 1'b0, 1'b0, 16'h0000, 1'b0, 1'b0},
      {1'b0, MASTER_DEBUG, 2'b01, 1'b1, 1'b1, 16'h0000, 1'b0, 1'b0},
      {1'b0, MASTER_CORE,  2'b01, 1'b1, 1'b1, 16'h0200, 1'b0, 1'b0},
      {1'b1, MASTER_DEBUG, 2'b10, 1'b1, 1'b0, 16'h0000, 1'b1, 1'b0},
      {1'b0, MASTER_CORE,  2'b10, 1'b0, 1'b0, 16'h0000, 1'b0, 1'b0}
   };

   string row_name [NUM_ROWS] = '{
      "core fetch, debug kept out", "core write region 1, error",
      "core read region 2", "core write region 3", "core read region 4",
      "core read region 5", "core read region 6", "core fetch region 7",
      "debug read, error", "debug external write", "debug PPB write word 3",
      "debug PPB read word 15", "core PPB write word 5", "core PPB fetch dropped",
      "debug PPB out of range", "core PPB read with stall",
      "debug read with stall, error", "idle bus"
   };

   // ---------------------------------------------------------------------
   // DUT and clock
   // ---------------------------------------------------------------------

   logic                   hclk;
   logic                   arst_n;
   core_req_t              core_req;
   dbg_req_t               dbg_req;
   logic [DATA_W-1:0]      core_wdata;
   logic [DATA_W-1:0]      dbg_wdata;
   logic [DATA_W-1:0]      hrdata;
   logic [DATA_W-1:0]      ppb_rdata;
   logic                   hready;
   logic                   hresp;
   logic [ADDR_W-1:0]      haddr;
   logic [1:0]             htrans;
   logic [2:0]             hsize;
   logic [3:0]             hprot;
   logic                   hwrite;
   logic                   hmaster;
   logic [2:0]             hburst;
   logic                   hmastlock;
   logic [DATA_W-1:0]      hwdata;
   logic [DATA_W-1:0]      ppb_wdata;
   logic [NUM_PPB_SEL-1:0] ppb_sels;
   logic                   ppb_active;
   logic                   ppb_write;
   logic [DATA_W-1:0]      dif_rdata;
   logic                   dif_resp;
   logic                   cpu_resp;
   logic                   dif_slot;

   integer seed = 32'h53b22cfd;
   int     errors;
   int     fails;

   tb_clkgen #(
      .PERIOD     (CLK_PERIOD),
      .RST_CYCLES (4)
   ) u_clkgen (
      .clk_o    (hclk),
      .arst_n_o (arst_n)
   );

   mtx_top #(
      .NUM_PPB_SEL (NUM_PPB_SEL)
   ) dut (
      .hclk         (hclk),
      .arst_n_i     (arst_n),
      .core_req_i   (core_req),
      .dbg_req_i    (dbg_req),
      .core_wdata_i (core_wdata),
      .dbg_wdata_i  (dbg_wdata),
      .hrdata_i     (hrdata),
      .hready_i     (hready),
      .hresp_i      (hresp),
      .ppb_rdata_i  (ppb_rdata),
      .haddr_o      (haddr),
      .htrans_o     (htrans),
      .hsize_o      (hsize),
      .hprot_o      (hprot),
      .hwrite_o     (hwrite),
      .hmaster_o    (hmaster),
      .hburst_o     (hburst),
      .hmastlock_o  (hmastlock),
      .hwdata_o     (hwdata),
      .ppb_wdata_o  (ppb_wdata),
      .ppb_sels_o   (ppb_sels),
      .ppb_active_o (ppb_active),
      .ppb_write_o  (ppb_write),
      .dif_rdata_o  (dif_rdata),
      .dif_resp_o   (dif_resp),
      .cpu_resp_o   (cpu_resp),
      .dif_slot_o   (dif_slot)
   );

   // ---------------------------------------------------------------------
   // compare tasks
   // ---------------------------------------------------------------------

   task automatic compare_value(input string sig, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
      if (act_v !== exp_v) begin
         $display("[FAIL] %0d ns %s expected %h got %h", $time, sig, exp_v, act_v);
         errors++;
      end
   endtask

   // address phase, including the fixed AHB outputs and the debug slot
   task automatic check_bus_req(input bus_req_t exp_req, input logic exp_slot);
      logic [1:0] exp_trans;
      exp_trans = exp_req.ext_trans ? HTRANS_NONSEQ : HTRANS_IDLE;
      compare_value("haddr_o", exp_req.addr, haddr);
      compare_value("htrans_o", 32'(exp_trans), 32'(htrans));
      compare_value("hsize_o", 32'(exp_req.size), 32'(hsize));
      compare_value("hwrite_o", 32'(exp_req.write), 32'(hwrite));
      compare_value("hmaster_o", 32'(exp_req.master), 32'(hmaster));
      compare_value("hprot_o[0]", 32'(exp_req.data_not_fetch), 32'(hprot[0]));
      compare_value("hburst_o", 32'(HBURST_SINGLE), 32'(hburst));
      compare_value("hmastlock_o", 32'd0, 32'(hmastlock));
      compare_value("dif_slot_o", 32'(exp_slot), 32'(dif_slot));
   endtask

   // memory attributes, privileged bit always set
   task automatic check_attr(input mem_attr_t exp_attr);
      compare_value("hprot_o[3]", 32'(exp_attr.cacheable), 32'(hprot[3]));
      compare_value("hprot_o[2]", 32'(exp_attr.bufferable), 32'(hprot[2]));
      compare_value("hprot_o[1]", 32'd1, 32'(hprot[1]));
   endtask

   task automatic check_data(input logic [DATA_W-1:0] exp_hwdata,
                             input logic [DATA_W-1:0] exp_ppb_wdata,
                             input logic [DATA_W-1:0] exp_rdata,
                             input logic exp_dresp, input logic exp_cresp);
      compare_value("hwdata_o", exp_hwdata, hwdata);
      compare_value("ppb_wdata_o", exp_ppb_wdata, ppb_wdata);
      compare_value("dif_rdata_o", exp_rdata, dif_rdata);
      compare_value("dif_resp_o", 32'(exp_dresp), 32'(dif_resp));
      compare_value("cpu_resp_o", 32'(exp_cresp), 32'(cpu_resp));
   endtask

   task automatic check_sels(input logic [NUM_PPB_SEL-1:0] exp_sels,
                             input logic exp_active, input logic exp_write);
      compare_value("ppb_sels_o", 32'(exp_sels), 32'(ppb_sels));
      compare_value("ppb_active_o", 32'(exp_active), 32'(ppb_active));
      compare_value("ppb_write_o", 32'(exp_write), 32'(ppb_write));
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (errors == errs_before) begin
         $display("[ok]   %s", name);
      end else begin
         $display("[bad]  %s, %0d mismatches", name, errors - errs_before);
         fails++;
      end
   endtask

   // random address inside the row's region, PPB keeps the word index
   function automatic logic [ADDR_W-1:0] make_addr(input stim_t s, input logic [31:0] rnd);
      if (s.region == PPB_NIBBLE) begin
         return {s.region, 18'd0, s.word, rnd[1:0]};
      end
      return {s.region, rnd[27:0]};
   endfunction

   // ---------------------------------------------------------------------
   // one table row, address phase then data phase
   // ---------------------------------------------------------------------

   task automatic run_row(input int idx);
      stim_t             s;
      expect_t           e;
      core_req_t         creq;
      dbg_req_t          dreq;
      bus_req_t          exp_req;
      logic [DATA_W-1:0] cwd;
      logic [DATA_W-1:0] dwd;
      logic [DATA_W-1:0] hrd;
      logic [DATA_W-1:0] prd;
      logic [DATA_W-1:0] exp_hwdata;
      logic [DATA_W-1:0] exp_ppb_wdata;
      logic              dbg_dphase;
      logic              exp_write;
      logic              exp_slot;
      int                errs_before;
      s = stim_tab[idx];
      e = expect_tab[idx];
      errs_before = errors;
      // loser gets the opposite write and another size
      creq.addr           = make_addr(s, $random(seed));
      creq.size           = SIZE_WORD;
      creq.write          = (e.master == MASTER_CORE) ? s.write : ~s.write;
      creq.data_not_fetch = s.cdnf;
      creq.spec_trans     = s.spec;
      creq.ext_trans      = s.cext;
      creq.ppb_trans      = s.cppb;
      dreq.addr           = make_addr(s, $random(seed));
      dreq.size           = SIZE_BYTE;
      dreq.write          = (e.master == MASTER_DEBUG) ? s.write : ~s.write;
      dreq.trans          = s.dtrans;
      exp_req.addr           = (e.master == MASTER_DEBUG) ? dreq.addr : creq.addr;
      exp_req.size           = (e.master == MASTER_DEBUG) ? SIZE_BYTE : SIZE_WORD;
      exp_req.write          = s.write;
      exp_req.data_not_fetch = e.dnf;
      exp_req.master         = e.master;
      exp_req.ext_trans      = e.nonseq;
      exp_req.ppb_trans      = e.ppb;
      // slot is open whenever the core is not speculating
      exp_slot = ~s.spec;
      cwd = $random(seed);
      dwd = $random(seed);
      hrd = $random(seed);
      prd = $random(seed);
      // data phase expectations from the steering rules
      dbg_dphase    = (e.nonseq | e.ppb) & (e.master == MASTER_DEBUG);
      exp_hwdata    = dbg_dphase ? dwd : cwd;
      exp_write     = e.ppb & s.write;
      exp_ppb_wdata = exp_write ? exp_hwdata : '0;

      // address phase
      @(posedge hclk);
      core_req <= creq;
      dbg_req  <= dreq;
      hready   <= 1'b1;
      @(negedge hclk);
      check_bus_req(exp_req, exp_slot);
      check_attr(e.attr);

      // accepting edge, bus goes idle behind it
      @(posedge hclk);
      core_req   <= '0;
      dbg_req    <= '0;
      core_wdata <= cwd;
      dbg_wdata  <= dwd;
      hrdata     <= hrd;
      ppb_rdata  <= prd;
      hresp      <= s.hresp;
      hready     <= (s.stall == 3'd0);
      @(negedge hclk);
      check_data(exp_hwdata, exp_ppb_wdata, e.ppb ? prd : hrd, e.dresp, e.cresp);
      check_sels(e.sels, e.ppb, exp_write);

      // stalled cycles, data phase must hold
      for (int k = 0; k < int'(s.stall); k++) begin
         @(posedge hclk);
         hready <= (k == int'(s.stall) - 1);
         @(negedge hclk);
         check_data(exp_hwdata, exp_ppb_wdata, e.ppb ? prd : hrd, e.dresp, e.cresp);
         check_sels(e.sels, e.ppb, exp_write);
      end
      report_test(row_name[idx], errs_before);
   endtask

   // ---------------------------------------------------------------------
   // main sequence and watchdog
   // ---------------------------------------------------------------------

   initial begin
      int errs_before;
      core_req   = '0;
      dbg_req    = '0;
      core_wdata = '0;
      dbg_wdata  = '0;
      hrdata     = '0;
      ppb_rdata  = '0;
      hready     = 1'b1;
      hresp      = 1'b1;
      errors     = 0;
      fails      = 0;

      // idle data phase after reset, errors on hresp reach nobody
      @(posedge arst_n);
      @(negedge hclk);
      errs_before = errors;
      check_sels('0, 1'b0, 1'b0);
      compare_value("dif_resp_o", 32'd0, 32'(dif_resp));
      compare_value("cpu_resp_o", 32'd0, 32'(cpu_resp));
      report_test("reset state", errs_before);

      for (int i = 0; i < NUM_ROWS; i++) begin
         run_row(i);
      end

      $display("tests run %0d, failed %0d, mismatches %0d", NUM_ROWS + 1, fails, errors);
      if (errors == 0 && fails == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // longest row is well under 20 cycles
   initial begin
      #((NUM_ROWS * 20 + 50) * CLK_PERIOD);
      $display("watchdog expired before the table was done");
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
common/mtx_pkg.sv
matrix/mtx_addr_decode.sv
matrix/mtx_arbiter.sv
matrix/mtx_dphase.sv
matrix/mtx_top.sv
test/tb_clkgen.sv
test/tb_mtx_top.sv

/* Makefile */
# build and run the bus matrix testbench with Verilator

TOP := tb_mtx_top

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
